// File: all.f
+incdir+src
src/cw_pkg.sv
src/cw_reg_file.sv
src/cw_trigger_route.sv
src/cw_target_io.sv
src/cw_io_top.sv
dv/cw_io_sva.sv
dv/cw_io_tb.sv

// File: dv/cw_io_cases.txt
# W addr bytecnt data | R addr bytecnt expdata | H hypaddr explen | S expstatic (11 bits) | X count
# P trig targetio tx usi | exp: trigger_o trigger_ext_o targetio_o targetio_oe uart_rx usi_in
R 27 0 01
R 28 0 00
R 37 0 01
R 37 1 02
R 37 7 00
R 3b 0 00
R 3f 0 00
H 27 0001
H 28 0001
H 37 0008
H 3b 0001
H 05 0000
S 001
P 000 2 1 0 0 0 1 1 1 1
P 001 0 0 0 1 1 0 1 0 1
W 27 0 0d
P 004 0 0 0 1 1 0 1 0 1
P 002 0 0 0 0 0 0 1 0 1
W 27 0 4d
P 00d 0 0 0 1 1 0 1 0 1
P 009 0 0 0 0 0 0 1 0 1
W 27 0 8d
P 00d 0 0 0 0 0 0 1 0 1
P 000 0 0 0 1 1 0 1 0 1
W 27 0 cd
P 03f 0 0 0 0 0 0 1 0 1
W 27 0 56
X 8
W 27 0 96
X 8
W 27 0 3f
X 8
R 27 0 3f
W 28 0 01
P 040 0 0 0 1 0 0 1 0 1
W 28 0 02
P 080 0 0 0 1 0 0 1 0 1
P 040 0 0 0 0 0 0 1 0 1
W 28 0 03
P 100 0 0 0 1 0 0 1 0 1
W 28 0 0c
P 1c1 0 0 0 0 1 0 1 0 1
S 007
W 28 0 08
P 001 0 0 0 1 1 0 1 0 1
R 28 0 08
W 28 0 00
S 001
W 37 0 85
W 37 1 cc
W 37 2 ca
W 37 3 82
P 000 c 1 0 0 0 5 f 1 0
P 000 2 0 1 0 0 6 f 0 1
R 37 2 ca
W 37 2 10
P 000 0 0 1 0 0 2 b 0 0
P 000 8 1 0 0 0 1 f 1 0
W 37 2 20
P 000 0 1 0 0 0 1 b 0 0
W 37 3 06
P 000 8 1 1 0 0 3 3 1 0
W 37 1 04
W 37 3 00
P 000 0 0 0 0 0 0 7 1 1
W 37 5 03
S 201
P 000 0 1 0 0 0 1 0 1 1
S 601
W 37 6 3f
S 7f9
W 37 6 15
S 751
W 37 5 00
S 551
P 000 a 0 0 0 0 0 7 1 1
S 151
R 3b 0 0a
W 3b 0 ff
R 3b 0 0a
W 37 8 ff
R 37 0 85

// File: dv/cw_io_sva.sv
`include "cw_defines.svh"

module cw_io_sva (
	input logic                 clk,
	input logic                 reset,
	input logic                 reg_read_i,
	input logic                 reg_addrvalid_i,
	input cw_pkg::cw_byte_t     reg_datao_o,
	input logic                 targetpower_off_o,
	input cw_pkg::cw_targetio_t targetio_oe_o,
	input logic                 fpa_oe_o,
	input cw_pkg::cw_byte_t     trigmod     // internal register of the top level
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // read by the testbench at the end of the run

	// read data bus idles at zero
	a_datao_idle: assert property (@(posedge clk) disable iff (reset)
		!$past(reg_read_i && reg_addrvalid_i) |-> (reg_datao_o == '0))
		else begin
			fail_count++;
			$error("reg_datao_o not zero without a valid read in the previous cycle");
		end

	// power off forces every target line into high-z
	a_pwroff_hiz: assert property (@(posedge clk) disable iff (reset)
		targetpower_off_o |-> (targetio_oe_o == '0))
		else begin
			fail_count++;
			$error("target io enabled while target power is off");
		end

	a_fpa_oe: assert property (@(posedge clk) disable iff (reset)
		fpa_oe_o == trigmod[`CW_TRIGMOD_FPA_BIT])
		else begin
			fail_count++;
			$error("fpa_oe_o differs from trigmod fpa bit");
		end

endmodule

bind cw_io_top cw_io_sva u_sva (
	.clk               (clk),
	.reset             (reset),
	.reg_read_i        (reg_read_i),
	.reg_addrvalid_i   (reg_addrvalid_i),
	.reg_datao_o       (reg_datao_o),
	.targetpower_off_o (targetpower_off_o),
	.targetio_oe_o     (targetio_oe_o),
	.fpa_oe_o          (fpa_oe_o),
	.trigmod           (trigmod)
);

// File: dv/cw_io_tb.sv
`include "cw_defines.svh"

module cw_io_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cw_pkg::*;

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 10;
	localparam int CYCLES_PER_CASE = 20; // watchdog budget per case

	logic         clk = 1'b0;
	logic         reset;
	cw_addr_t     reg_address_i, reg_hypaddress_i;
	cw_bytecnt_t  reg_bytecnt_i;
	cw_byte_t     reg_datai_i, reg_datao_o;
	logic         reg_read_i, reg_write_i, reg_addrvalid_i;
	cw_hyplen_t   reg_hyplen_o;
	logic         trigger_fpa_i, trigger_nrst_i, trigger_advio_i;
	logic         trigger_anapattern_i, trigger_decodedio_i;
	cw_targetio_t trigger_io_i, targetio_i, targetio_o, targetio_oe_o;
	logic         trigger_o, trigger_ext_o, fpa_o, fpa_oe_o, led_auxi_o, led_auxo_o;
	logic         uart_tx_i, uart_rx_o, usi_out_i, usi_in_o;
	logic         targetpower_off_o, enable_avrprog_o;
	logic         enable_output_nrst_o, output_nrst_o, enable_output_pdid_o;
	logic         output_pdid_o, enable_output_pdic_o, output_pdic_o;

	int       errors = 0;
	int       checks = 0;
	int       seed = 86996;
	int       wd_cycles = 0;
	logic     wd_armed = 1'b0;
	logic     case_bad;
	cw_byte_t trigsrc_shadow = `CW_TRIGSRC_RST; // last value written to trigsrc
	string    cases[$];

	cw_io_top u_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
			case_bad = 1'b1;
		end
	endtask

	// unmasked lines are ignored in OR and count as 1 in AND and NAND
	function automatic logic comb_expect(input cw_byte_t src, input logic [5:0] lines);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (src[i]) begin
				any_hi = any_hi | lines[i];
				all_hi = all_hi & lines[i];
			end
		end
		case (src[7:6])
			2'd0:    return any_hi;
			2'd1:    return all_hi;
			2'd2:    return ~all_hi;
			default: return 1'b0; // off
		endcase
	endfunction

	task automatic bus_write(input cw_addr_t addr, input cw_bytecnt_t cnt, input cw_byte_t data);
		@(posedge clk);
		#5;
		reg_address_i = addr;
		reg_bytecnt_i = cnt;
		reg_datai_i   = data;
		reg_write_i   = 1'b1;
		@(posedge clk); // register takes the write here
		#5;
		reg_write_i = 1'b0;
		if (addr == `CW_TRIGSRC_ADDR)
			trigsrc_shadow = data;
	endtask

	task automatic bus_read(input cw_addr_t addr, input cw_bytecnt_t cnt, input cw_byte_t exp);
		@(posedge clk);
		#5;
		reg_address_i   = addr;
		reg_bytecnt_i   = cnt;
		reg_read_i      = 1'b1;
		reg_addrvalid_i = 1'b1;
		@(posedge clk); // strobe sampled and data registered
		#5;
		reg_read_i      = 1'b0;
		reg_addrvalid_i = 1'b0;
		@(negedge clk);
		check_val("reg_datao_o", 16'(reg_datao_o), 16'(exp));
	endtask

	task automatic hyplen_check(input cw_addr_t addr, input cw_hyplen_t exp);
		@(posedge clk);
		#5;
		reg_hypaddress_i = addr;
		@(negedge clk);
		check_val("reg_hyplen_o", reg_hyplen_o, exp);
	endtask

	// exp bit 10 power off, 9 avrprog, 8..3 nrst/pdid/pdic en and lvl, 2 fpa_oe, 1 auxo, 0 auxi
	task automatic static_check(input logic [10:0] exp);
		@(negedge clk);
		check_val("targetpower_off_o", 16'(targetpower_off_o), 16'(exp[10]));
		check_val("enable_avrprog_o", 16'(enable_avrprog_o), 16'(exp[9]));
		check_val("enable_output_nrst_o", 16'(enable_output_nrst_o), 16'(exp[8]));
		check_val("output_nrst_o", 16'(output_nrst_o), 16'(exp[7]));
		check_val("enable_output_pdid_o", 16'(enable_output_pdid_o), 16'(exp[6]));
		check_val("output_pdid_o", 16'(output_pdid_o), 16'(exp[5]));
		check_val("enable_output_pdic_o", 16'(enable_output_pdic_o), 16'(exp[4]));
		check_val("output_pdic_o", 16'(output_pdic_o), 16'(exp[3]));
		check_val("fpa_oe_o", 16'(fpa_oe_o), 16'(exp[2]));
		check_val("led_auxo_o", 16'(led_auxo_o), 16'(exp[1]));
		check_val("led_auxi_o", 16'(led_auxi_o), 16'(exp[0]));
	endtask

	// trig bit 0 fpa, 1 nrst, 5..2 io1..4, 6 advio, 7 anapattern, 8 decodedio
	task automatic pin_step(input logic [8:0] trig, input cw_targetio_t tio, input logic tx,
			input logic usi, input logic e_trig, input logic e_ext, input cw_targetio_t e_out,
			input cw_targetio_t e_oe, input logic e_rx, input logic e_usi);
		@(posedge clk);
		#5;
		trigger_fpa_i        = trig[0];
		trigger_nrst_i       = trig[1];
		trigger_io_i         = trig[5:2];
		trigger_advio_i      = trig[6];
		trigger_anapattern_i = trig[7];
		trigger_decodedio_i  = trig[8];
		targetio_i           = tio;
		uart_tx_i            = tx;
		usi_out_i            = usi;
		@(negedge clk);
		check_val("trigger_o", 16'(trigger_o), 16'(e_trig));
		check_val("trigger_ext_o", 16'(trigger_ext_o), 16'(e_ext));
		check_val("fpa_o", 16'(fpa_o), 16'(e_trig)); // fpa mirrors trigger_o
		check_val("targetio_o", 16'(targetio_o), 16'(e_out));
		check_val("targetio_oe_o", 16'(targetio_oe_o), 16'(e_oe));
		check_val("uart_rx_o", 16'(uart_rx_o), 16'(e_rx));
		check_val("usi_in_o", 16'(usi_in_o), 16'(e_usi));
	endtask

	task automatic random_lines(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			@(posedge clk);
			#5;
			trigger_fpa_i  = r[0];
			trigger_nrst_i = r[1];
			trigger_io_i   = r[5:2];
			@(negedge clk);
			check_val("trigger_ext_o", 16'(trigger_ext_o),
				16'(comb_expect(trigsrc_shadow, r[5:0])));
		end
	endtask

	initial begin : watchdog
		wait (wd_armed);
		#(wd_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the case list did not complete", wd_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int           fd;
		int           total;
		int           n_rand;
		int           sva_fails;
		string        ln;
		logic [7:0]   kind;
		cw_addr_t     addr;
		cw_bytecnt_t  cnt;
		cw_byte_t     data;
		cw_hyplen_t   hlen;
		logic [10:0]  stat;
		logic [8:0]   trig;
		cw_targetio_t tio, e_out, e_oe;
		logic         tx, usi, e_trig, e_ext, e_rx, e_usi;
		reset = 1'b1;
		reg_address_i = '0;
		reg_hypaddress_i = '0;
		reg_bytecnt_i = '0;
		reg_datai_i = '0;
		reg_read_i = 1'b0;
		reg_write_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		trigger_fpa_i = 1'b0;
		trigger_nrst_i = 1'b0;
		trigger_io_i = '0;
		trigger_advio_i = 1'b0;
		trigger_anapattern_i = 1'b0;
		trigger_decodedio_i = 1'b0;
		targetio_i = '0;
		uart_tx_i = 1'b0;
		usi_out_i = 1'b0;
		total = 0;
		fd = $fopen("dv/cw_io_cases.txt", "r");
		if (fd == 0)
			$display("case file dv/cw_io_cases.txt could not be opened");
		while (fd != 0 && !$feof(fd)) begin
			ln = "";
			void'($fgets(ln, fd));
			if (ln.len() > 1 && ln.getc(0) != "#") begin // skip blanks and comments
				cases.push_back(ln);
				if (ln.getc(0) == "X") begin
					void'($sscanf(ln, "%c %d", kind, n_rand));
					total += n_rand;
				end else begin
					total++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		wd_cycles = (total + RESET_CYCLES) * CYCLES_PER_CASE;
		wd_armed  = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;
		foreach (cases[n]) begin
			ln = cases[n];
			kind = ln.getc(0);
			case_bad = 1'b0;
			case (kind)
				"W": begin
					void'($sscanf(ln, "%c %h %h %h", kind, addr, cnt, data));
					bus_write(addr, cnt, data);
				end
				"R": begin
					void'($sscanf(ln, "%c %h %h %h", kind, addr, cnt, data));
					bus_read(addr, cnt, data);
				end
				"H": begin
					void'($sscanf(ln, "%c %h %h", kind, addr, hlen));
					hyplen_check(addr, hlen);
				end
				"S": begin
					void'($sscanf(ln, "%c %h", kind, stat));
					static_check(stat);
				end
				"P": begin
					void'($sscanf(ln, "%c %h %h %h %h %h %h %h %h %h %h", kind, trig, tio, tx,
						usi, e_trig, e_ext, e_out, e_oe, e_rx, e_usi));
					pin_step(trig, tio, tx, usi, e_trig, e_ext, e_out, e_oe, e_rx, e_usi);
				end
				"X": begin
					void'($sscanf(ln, "%c %d", kind, n_rand));
					random_lines(n_rand);
				end
				default: begin
					$display("case line %0d has an unknown kind '%c'", n + 1, kind);
					errors++;
					case_bad = 1'b1;
				end
			endcase
			$display("test %0d (%c) %s", n + 1, kind, case_bad ? "mismatch" : "ok");
		end
		sva_fails = u_dut.u_sva.fail_count;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			cases.size(), checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0 && checks > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the cw_io testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cw_io_tb -Mdir obj_dir -o cw_io_sim -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cw_io_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: src/cw_defines.svh
`ifndef CW_DEFINES_SVH
`define CW_DEFINES_SVH

// register map
`define CW_TRIGSRC_ADDR    6'd39 // trigger source mask and combine mode
`define CW_TRIGMOD_ADDR    6'd40 // trigger module select, fpa drive
`define CW_IOROUTE_ADDR    6'd55 // 8 byte routing word
`define CW_IOREAD_ADDR     6'd59 // target io pin read-back, read only

// widths
`define CW_ADDR_W          6
`define CW_BYTE_W          8
`define CW_BYTECNT_W       16
`define CW_HYPLEN_W        16
`define CW_IOROUTE_BYTES   8
`define CW_NUM_TARGETIO    4
`define CW_NUM_USI_LINES   3  // usi only on lines 1..3
`define CW_OC_LINE         2  // zero based index of line 3, open collector modes
`define CW_TRIG_NSRC       6  // fpa, nrst, io1..io4

// reset values
`define CW_TRIGSRC_RST     8'h01
`define CW_TRIGMOD_RST     8'h00
`define CW_IOROUTE_RST     64'h0000_0000_0000_0201 // gpio1 tx, gpio2 rx

// bits inside a gpio routing byte
`define CW_GPIO_TX         0
`define CW_GPIO_RX         1
`define CW_GPIO_USIO       2
`define CW_GPIO_USII       3
`define CW_GPIO_USOC       4
`define CW_GPIO_TXO        5
`define CW_GPIO_LVL        6
`define CW_GPIO_EN         7

// bits in the extra bytes of the routing word
`define CW_AVRPROG_BIT     40
`define CW_PWROFF_BIT      41
`define CW_NRST_EN_BIT     48
`define CW_NRST_BIT        49
`define CW_PDID_EN_BIT     50
`define CW_PDID_BIT        51
`define CW_PDIC_EN_BIT     52
`define CW_PDIC_BIT        53

`define CW_TRIGMOD_FPA_BIT 3  // trigger out on front panel a

`endif

// File: src/cw_io_top.sv
module cw_io_top (
	input  logic                 clk,
	input  logic                 reset,
	// register bus
	input  cw_pkg::cw_addr_t     reg_address_i,
	input  cw_pkg::cw_bytecnt_t  reg_bytecnt_i,
	input  cw_pkg::cw_byte_t     reg_datai_i,
	input  logic                 reg_read_i,
	input  logic                 reg_write_i,
	input  logic                 reg_addrvalid_i,
	input  cw_pkg::cw_addr_t     reg_hypaddress_i,
	output cw_pkg::cw_byte_t     reg_datao_o,
	output cw_pkg::cw_hyplen_t   reg_hyplen_o,
	// trigger
	input  logic                 trigger_fpa_i,
	input  logic                 trigger_nrst_i,
	input  cw_pkg::cw_targetio_t trigger_io_i,
	input  logic                 trigger_advio_i,
	input  logic                 trigger_anapattern_i,
	input  logic                 trigger_decodedio_i,
	output logic                 trigger_o,
	output logic                 trigger_ext_o,
	output logic                 fpa_o,
	output logic                 fpa_oe_o,
	output logic                 led_auxi_o,
	output logic                 led_auxo_o,
	// target io
	input  cw_pkg::cw_targetio_t targetio_i,
	output cw_pkg::cw_targetio_t targetio_o,
	output cw_pkg::cw_targetio_t targetio_oe_o,
	input  logic                 uart_tx_i,
	output logic                 uart_rx_o,
	input  logic                 usi_out_i,
	output logic                 usi_in_o,
	output logic                 targetpower_off_o,
	output logic                 enable_avrprog_o,
	output logic                 enable_output_nrst_o,
	output logic                 output_nrst_o,
	output logic                 enable_output_pdid_o,
	output logic                 output_pdid_o,
	output logic                 enable_output_pdic_o,
	output logic                 output_pdic_o
);
	import cw_pkg::*;

	cw_byte_t     trigsrc;
	cw_byte_t     trigmod;
	cw_ioroute_t  ioroute;
	cw_targetio_t ioread; // sampled pins back to the register file

	cw_reg_file u_reg_file (
		.clk              (clk),
		.reset            (reset),
		.reg_address_i    (reg_address_i),
		.reg_bytecnt_i    (reg_bytecnt_i),
		.reg_datai_i      (reg_datai_i),
		.reg_read_i       (reg_read_i),
		.reg_write_i      (reg_write_i),
		.reg_addrvalid_i  (reg_addrvalid_i),
		.reg_hypaddress_i (reg_hypaddress_i),
		.ioread_i         (ioread),
		.reg_datao_o      (reg_datao_o),
		.reg_hyplen_o     (reg_hyplen_o),
		.trigsrc_o        (trigsrc),
		.trigmod_o        (trigmod),
		.ioroute_o        (ioroute)
	);

	cw_trigger_route u_trigger_route (
		.trigsrc_i            (trigsrc),
		.trigmod_i            (trigmod),
		.trigger_fpa_i        (trigger_fpa_i),
		.trigger_nrst_i       (trigger_nrst_i),
		.trigger_io_i         (trigger_io_i),
		.trigger_advio_i      (trigger_advio_i),
		.trigger_anapattern_i (trigger_anapattern_i),
		.trigger_decodedio_i  (trigger_decodedio_i),
		.trigger_o            (trigger_o),
		.trigger_ext_o        (trigger_ext_o),
		.fpa_o                (fpa_o),
		.fpa_oe_o             (fpa_oe_o),
		.led_auxi_o           (led_auxi_o),
		.led_auxo_o           (led_auxo_o)
	);

	cw_target_io u_target_io (
		.clk                  (clk),
		.reset                (reset),
		.ioroute_i            (ioroute),
		.targetio_i           (targetio_i),
		.targetio_o           (targetio_o),
		.targetio_oe_o        (targetio_oe_o),
		.uart_tx_i            (uart_tx_i),
		.uart_rx_o            (uart_rx_o),
		.usi_out_i            (usi_out_i),
		.usi_in_o             (usi_in_o),
		.ioread_o             (ioread),
		.targetpower_off_o    (targetpower_off_o),
		.enable_avrprog_o     (enable_avrprog_o),
		.enable_output_nrst_o (enable_output_nrst_o),
		.output_nrst_o        (output_nrst_o),
		.enable_output_pdid_o (enable_output_pdid_o),
		.output_pdid_o        (output_pdid_o),
		.enable_output_pdic_o (enable_output_pdic_o),
		.output_pdic_o        (output_pdic_o)
	);

endmodule

// File: src/cw_pkg.sv
`include "cw_defines.svh"

package cw_pkg;

	typedef logic [`CW_ADDR_W-1:0]                  cw_addr_t;     // register address
	typedef logic [`CW_BYTE_W-1:0]                  cw_byte_t;     // register data
	typedef logic [`CW_BYTECNT_W-1:0]               cw_bytecnt_t;  // byte index in a transfer
	typedef logic [`CW_HYPLEN_W-1:0]                cw_hyplen_t;   // register length in bytes
	typedef logic [`CW_IOROUTE_BYTES*`CW_BYTE_W-1:0] cw_ioroute_t; // gpio1..4, glitch, extra
	typedef logic [`CW_NUM_TARGETIO-1:0]            cw_targetio_t; // one bit per target line

	// trigsrc bits 7:6
	typedef enum logic [1:0] {
		TRIG_OR   = 2'd0,
		TRIG_AND  = 2'd1, // unmasked lines count as 1
		TRIG_NAND = 2'd2,
		TRIG_OFF  = 2'd3
	} cw_trig_comb_e;

	// trigmod bits 2:0, codes 4..7 give no trigger
	typedef enum logic [2:0] {
		TRIGMOD_EDGE       = 3'd0, // external combine
		TRIGMOD_ADVIO      = 3'd1,
		TRIGMOD_ANAPATTERN = 3'd2,
		TRIGMOD_DECODEDIO  = 3'd3
	} cw_trig_module_e;

endpackage

// File: src/cw_reg_file.sv
`include "cw_defines.svh"

module cw_reg_file (
	input  logic                clk,
	input  logic                reset,
	input  cw_pkg::cw_addr_t    reg_address_i,
	input  cw_pkg::cw_bytecnt_t reg_bytecnt_i,
	input  cw_pkg::cw_byte_t    reg_datai_i,
	input  logic                reg_read_i,      // single cycle strobe
	input  logic                reg_write_i,     // single cycle strobe
	input  logic                reg_addrvalid_i, // level
	input  cw_pkg::cw_addr_t    reg_hypaddress_i,
	input  cw_pkg::cw_targetio_t ioread_i,
	output cw_pkg::cw_byte_t    reg_datao_o,
	output cw_pkg::cw_hyplen_t  reg_hyplen_o,
	output cw_pkg::cw_byte_t    trigsrc_o,
	output cw_pkg::cw_byte_t    trigmod_o,
	output cw_pkg::cw_ioroute_t ioroute_o
);
	import cw_pkg::*;

	cw_byte_t    trigsrc_q;
	cw_byte_t    trigmod_q;
	cw_ioroute_t ioroute_q;
	cw_byte_t    rdata_q;      // captured read data
	logic        rvalid_q;     // read hit a known register
	logic        addr_known;
	logic        byte_in_range; // bytecnt inside the routing word
	logic [2:0]  byte_sel;
	cw_byte_t    rdata_mux;

	assign byte_in_range = (reg_bytecnt_i < `CW_BYTECNT_W'(`CW_IOROUTE_BYTES));
	assign byte_sel      = reg_bytecnt_i[2:0];

	// address decode shared by read valid
	always_comb begin
		case (reg_address_i)
			`CW_TRIGSRC_ADDR,
			`CW_TRIGMOD_ADDR,
			`CW_IOROUTE_ADDR,
			`CW_IOREAD_ADDR: addr_known = 1'b1;
			default:         addr_known = 1'b0;
		endcase
	end

	// register writes with the routing word written bytewise
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= `CW_TRIGSRC_RST;
			trigmod_q <= `CW_TRIGMOD_RST;
			ioroute_q <= `CW_IOROUTE_RST;
		end else if (reg_write_i) begin
			case (reg_address_i)
				`CW_TRIGSRC_ADDR: trigsrc_q <= reg_datai_i;
				`CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i;
				`CW_IOROUTE_ADDR: begin
					if (byte_in_range)
						ioroute_q[{byte_sel, 3'b000} +: `CW_BYTE_W] <= reg_datai_i;
				end
				default: ; // ioread is read only
			endcase
		end
	end

	// read data select
	always_comb begin
		case (reg_address_i)
			`CW_TRIGSRC_ADDR: rdata_mux = trigsrc_q;
			`CW_TRIGMOD_ADDR: rdata_mux = trigmod_q;
			`CW_IOROUTE_ADDR: begin
				if (byte_in_range)
					rdata_mux = ioroute_q[{byte_sel, 3'b000} +: `CW_BYTE_W];
				else
					rdata_mux = '0;
			end
			`CW_IOREAD_ADDR:  rdata_mux = {{(`CW_BYTE_W-`CW_NUM_TARGETIO){1'b0}}, ioread_i};
			default:          rdata_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reg_read_i)
			rdata_q <= rdata_mux; // held until the next read strobe
	end

	always_ff @(posedge clk) begin
		if (reset)
			rvalid_q <= 1'b0;
		else
			rvalid_q <= reg_read_i & reg_addrvalid_i & addr_known;
	end

	assign reg_datao_o = rvalid_q ? rdata_q : '0; // zero unless a valid read last cycle

	// length of each register in bytes
	always_comb begin
		case (reg_hypaddress_i)
			`CW_TRIGSRC_ADDR: reg_hyplen_o = cw_hyplen_t'(1);
			`CW_TRIGMOD_ADDR: reg_hyplen_o = cw_hyplen_t'(1);
			`CW_IOROUTE_ADDR: reg_hyplen_o = cw_hyplen_t'(`CW_IOROUTE_BYTES);
			`CW_IOREAD_ADDR:  reg_hyplen_o = cw_hyplen_t'(1);
			default:          reg_hyplen_o = '0;
		endcase
	end

	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign ioroute_o = ioroute_q;

endmodule

// File: src/cw_target_io.sv
`include "cw_defines.svh"

module cw_target_io (
	input  logic                 clk,
	input  logic                 reset,
	input  cw_pkg::cw_ioroute_t  ioroute_i,
	input  cw_pkg::cw_targetio_t targetio_i,
	output cw_pkg::cw_targetio_t targetio_o,
	output cw_pkg::cw_targetio_t targetio_oe_o,
	input  logic                 uart_tx_i,
	output logic                 uart_rx_o,
	input  logic                 usi_out_i,
	output logic                 usi_in_o,
	output cw_pkg::cw_targetio_t ioread_o,
	output logic                 targetpower_off_o,
	output logic                 enable_avrprog_o,
	output logic                 enable_output_nrst_o,
	output logic                 output_nrst_o,
	output logic                 enable_output_pdid_o,
	output logic                 output_pdid_o,
	output logic                 enable_output_pdic_o,
	output logic                 output_pdic_o
);
	import cw_pkg::*;

	logic         pwroff_q; // delayed power-off bit, forces high-z
	cw_targetio_t ioread_q;

	// returns {oe, o} for one line, lowest set source wins
	function automatic logic [1:0] route_line(
		input cw_byte_t cfg,
		input logic     has_usi, // lines 1..3
		input logic     has_oc,  // line 3 only
		input logic     tx,
		input logic     usi
	);
		logic [1:0] res;
		res = 2'b00;
		if (cfg[`CW_GPIO_TX])
			res = {1'b1, tx};
		else if (has_usi && cfg[`CW_GPIO_USIO])
			res = {1'b1, usi};
		else if (has_oc && cfg[`CW_GPIO_USOC])
			res = {~usi, 1'b0}; // open collector, pull low only
		else if (has_oc && cfg[`CW_GPIO_TXO])
			res = {~tx, 1'b0};
		else if (cfg[`CW_GPIO_EN])
			res = {1'b1, cfg[`CW_GPIO_LVL]}; // plain gpio level
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			pwroff_q <= 1'b0;
		else
			pwroff_q <= ioroute_i[`CW_PWROFF_BIT];
	end

	for (genvar g = 0; g < `CW_NUM_TARGETIO; g++) begin : g_line
		logic [1:0] route;
		assign route = route_line(ioroute_i[g*`CW_BYTE_W +: `CW_BYTE_W],
			g < `CW_NUM_USI_LINES, g == `CW_OC_LINE, uart_tx_i, usi_out_i);
		assign targetio_oe_o[g] = route[1] & ~pwroff_q;
		assign targetio_o[g]    = route[0];
	end

	// rx from lowest numbered routed line, idle high otherwise
	always_comb begin
		uart_rx_o = 1'b1;
		for (int i = `CW_NUM_TARGETIO - 1; i >= 0; i--) begin
			if (ioroute_i[i*`CW_BYTE_W + `CW_GPIO_RX])
				uart_rx_o = targetio_i[i];
		end
	end

	always_comb begin
		usi_in_o = 1'b1;
		for (int i = `CW_NUM_USI_LINES - 1; i >= 0; i--) begin
			if (ioroute_i[i*`CW_BYTE_W + `CW_GPIO_USII])
				usi_in_o = targetio_i[i];
		end
	end

	// pin sample for the ioread register
	always_ff @(posedge clk) begin
		if (reset)
			ioread_q <= '0;
		else
			ioread_q <= targetio_i;
	end

	assign ioread_o          = ioread_q;
	assign targetpower_off_o = pwroff_q;

	// static controls straight from the extra bytes
	assign enable_avrprog_o     = ioroute_i[`CW_AVRPROG_BIT];
	assign enable_output_nrst_o = ioroute_i[`CW_NRST_EN_BIT];
	assign output_nrst_o        = ioroute_i[`CW_NRST_BIT];
	assign enable_output_pdid_o = ioroute_i[`CW_PDID_EN_BIT];
	assign output_pdid_o        = ioroute_i[`CW_PDID_BIT];
	assign enable_output_pdic_o = ioroute_i[`CW_PDIC_EN_BIT];
	assign output_pdic_o        = ioroute_i[`CW_PDIC_BIT];

endmodule

// File: src/cw_trigger_route.sv
`include "cw_defines.svh"

module cw_trigger_route (
	input  cw_pkg::cw_byte_t     trigsrc_i,
	input  cw_pkg::cw_byte_t     trigmod_i,
	input  logic                 trigger_fpa_i,
	input  logic                 trigger_nrst_i,
	input  cw_pkg::cw_targetio_t trigger_io_i,
	input  logic                 trigger_advio_i,
	input  logic                 trigger_anapattern_i,
	input  logic                 trigger_decodedio_i,
	output logic                 trigger_o,     // to capture system
	output logic                 trigger_ext_o, // combined external trigger
	output logic                 fpa_o,
	output logic                 fpa_oe_o,
	output logic                 led_auxi_o,
	output logic                 led_auxo_o
);
	import cw_pkg::*;

	logic [`CW_TRIG_NSRC-1:0] trig_lines; // {io4, io3, io2, io1, nrst, fpa}
	logic [`CW_TRIG_NSRC-1:0] trig_mask;
	logic                     trig_or;
	logic                     trig_and;
	cw_trig_comb_e            comb_mode;
	cw_trig_module_e          mod_sel;

	assign trig_lines = {trigger_io_i, trigger_nrst_i, trigger_fpa_i};
	assign trig_mask  = trigsrc_i[`CW_TRIG_NSRC-1:0];
	assign comb_mode  = cw_trig_comb_e'(trigsrc_i[7:6]);
	assign mod_sel    = cw_trig_module_e'(trigmod_i[2:0]);

	assign trig_or  = |(trig_lines & trig_mask);
	assign trig_and = &(trig_lines | ~trig_mask); // unmasked lines read as 1

	always_comb begin
		case (comb_mode)
			TRIG_OR:   trigger_ext_o = trig_or;
			TRIG_AND:  trigger_ext_o = trig_and;
			TRIG_NAND: trigger_ext_o = ~trig_and;
			default:   trigger_ext_o = 1'b0; // off
		endcase
	end

	always_comb begin
		case (mod_sel)
			TRIGMOD_EDGE:       trigger_o = trigger_ext_o;
			TRIGMOD_ADVIO:      trigger_o = trigger_advio_i;
			TRIGMOD_ANAPATTERN: trigger_o = trigger_anapattern_i;
			TRIGMOD_DECODEDIO:  trigger_o = trigger_decodedio_i;
			default:            trigger_o = 1'b0; // codes 4..7
		endcase
	end

	// front panel a doubles as trigger out
	assign fpa_o      = trigger_o;
	assign fpa_oe_o   = trigmod_i[`CW_TRIGMOD_FPA_BIT];
	assign led_auxo_o = trigmod_i[`CW_TRIGMOD_FPA_BIT];
	assign led_auxi_o = trigsrc_i[0]; // fpa used as trigger input

endmodule
